//--- Bender.yml
package:
  name: llc_tag_store

sources:
  - llc_tag_pkg.sv
  - tag_sram.sv
  - tag_bist_gen.sv
  - evict_select.sv
  - llc_tag_store.sv
  - target: simulation
    files:
      - tb_llc_tag_store.sv

//--- compile.f
llc_tag_pkg.sv
tag_sram.sv
tag_bist_gen.sv
evict_select.sv
llc_tag_store.sv
tb_llc_tag_store.sv

//--- evict_select.sv
// victim way selection on a lookup miss, invalid ways first, then round-robin over unlocked ways
`timescale 1ns/100ps
module evict_select
  import llc_tag_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_i,
  input  way_mask_t valid_i,
  input  way_mask_t dirty_i,
  input  way_mask_t spm_lock_i,
  input  logic      advance_i,
  output way_mask_t way_o,
  output logic      evict_o
);

  // way number for the round-robin pointer
  typedef logic [$clog2(num_ways)-1:0] ptr_t;

  ptr_t      ptr_q;
  ptr_t      chosen;
  logic      found;
  logic      use_rr;
  way_mask_t free;

  // invalid ways that may be refilled
  assign free   = ~valid_i & ~spm_lock_i;
  // full set, so fall back to round-robin
  assign use_rr = ~(|free);

  always_comb begin : proc_pick
    ptr_t idx;
    idx    = ptr_q;
    chosen = ptr_q;
    found  = 1'b0;
    if (use_rr) begin
      // first unlocked way at or after the pointer
      for (int k = 0; k < num_ways; k++) begin
        idx = ptr_t'(ptr_q + k);
        if (!found && !spm_lock_i[idx]) begin
          found  = 1'b1;
          chosen = idx;
        end
      end
    end else begin
      // lowest free way wins
      for (int i = num_ways - 1; i >= 0; i--) begin
        if (free[i]) begin
          found  = 1'b1;
          chosen = ptr_t'(i);
        end
      end
    end
  end

  always_comb begin : proc_out
    way_o   = '0;
    evict_o = 1'b0;
    if (req_i && found) begin
      way_o[chosen] = 1'b1;
      // only an occupied dirty line needs a write-back
      evict_o       = use_rr & dirty_i[chosen];
    end
  end

  // pointer only moves when a full-set victim was handed out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (advance_i && req_i && use_rr && found) begin
      ptr_q <= ptr_t'(chosen + 1'b1);
    end
  end

  // a miss with every way locked has no victim
  unlocked_way: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |-> |(~spm_lock_i))
    else $error("victim requested with all ways locked");

endmodule

//--- llc_tag_pkg.sv
// shared geometry, request modes and entry/request/result structs, imported by every tag array module
package llc_tag_pkg;

  // cache geometry
  localparam int unsigned num_ways    = 4;
  localparam int unsigned num_lines   = 16;
  localparam int unsigned index_width = 4;
  localparam int unsigned tag_width   = 8;

  // one bit per way
  typedef logic [num_ways-1:0]    way_mask_t;
  // set index, doubles as the memory address
  typedef logic [index_width-1:0] index_t;
  // upper address bits kept per line
  typedef logic [tag_width-1:0]   tag_t;

  // request modes
  // encoding order follows the control unit's case statements
  typedef enum logic [1:0] {
    mode_bist   = 2'd0,
    mode_flush  = 2'd1,
    mode_lookup = 2'd2,
    mode_store  = 2'd3
  } tag_req_e;

  // one stored line as it sits in a way memory
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // request from the cache controller
  typedef struct packed {
    tag_req_e  mode;
    // target ways for store, flush and bist
    way_mask_t way_mask;
    index_t    index;
    // dirty flag written with a store
    logic      dirty;
    tag_t      tag;
  } tag_req_t;

  // result of a lookup or a flush
  typedef struct packed {
    // hit way, victim way or flushed way
    way_mask_t way_mask;
    logic      hit;
    // line must be written back
    logic      evict;
    // tag and dirty flag of the indicated way
    tag_t      tag;
    logic      dirty;
  } tag_res_t;

endpackage

//--- llc_tag_store.sv
// tag array top level, accepts bist/flush/lookup/store requests and reports hit, victim and flush results
`timescale 1ns/100ps
module llc_tag_store
  import llc_tag_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  way_mask_t spm_lock_i,
  input  way_mask_t flushed_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  tag_req_t  req_i,
  output logic      res_valid_o,
  input  logic      res_ready_i,
  output tag_res_t  res_o,
  output way_mask_t bist_res_o,
  output logic      bist_valid_o
);

  // request held while busy
  logic       busy_q, busy_d;
  tag_req_e   mode_q, mode_d;
  way_mask_t  mask_q, mask_d;
  index_t     index_q, index_d;
  tag_entry_t tag_q, tag_d;
  // a bist read was issued last cycle
  logic       bist_rd_q, bist_rd_d;
  logic       accept_next;
  tag_entry_t new_entry;

  // memory side
  way_mask_t  ram_req, ram_we;
  index_t     ram_index;
  tag_entry_t ram_wdata;
  tag_entry_t [num_ways-1:0] rdata;

  // per-way compare results
  way_mask_t  valid_mask, dirty_mask, tag_match, hit, cmp;
  logic       hit_any;

  // bist sequencer
  logic       gen_start, gen_ready, gen_req, gen_we, gen_done;
  index_t     gen_index;
  tag_entry_t gen_pattern;

  // victim selection
  logic       evict_req, evict_advance, victim_evict;
  way_mask_t  victim;
  way_mask_t  res_way;

  // store writes a valid line and lookup keeps it only for the tag field
  assign new_entry.valid = 1'b1;
  assign new_entry.dirty = req_i.dirty;
  assign new_entry.tag   = req_i.tag;

  always_comb begin : proc_ctrl
    busy_d      = busy_q;
    mode_d      = mode_q;
    mask_d      = mask_q;
    index_d     = index_q;
    tag_d       = tag_q;
    bist_rd_d   = 1'b0;
    accept_next = 1'b0;
    req_ready_o = 1'b0;
    gen_start   = 1'b0;
    ram_req     = '0;
    ram_we      = '0;
    ram_index   = req_i.index;
    ram_wdata   = new_entry;
    if (busy_q) begin
      unique case (mode_q)
        mode_bist: begin
          // sequencer owns the memories of the selected ways
          ram_index = gen_index;
          ram_req   = gen_req ? mask_q : '0;
          ram_we    = gen_we ? mask_q : '0;
          ram_wdata = gen_pattern;
          // pattern lines up with the read data one cycle later
          tag_d     = gen_pattern;
          bist_rd_d = gen_req & ~gen_we;
          if (gen_done) begin
            busy_d = 1'b0;
          end
        end
        mode_flush: begin
          // clear the line as the result is taken
          if (res_ready_i) begin
            busy_d    = 1'b0;
            ram_index = index_q;
            ram_req   = mask_q;
            ram_we    = mask_q;
            ram_wdata = '0;
          end
        end
        mode_lookup: begin
          // a lookup or store may follow as soon as the result is taken
          if (res_ready_i) begin
            busy_d      = 1'b0;
            accept_next = 1'b1;
          end
        end
        default: begin
          busy_d = 1'b0;
        end
      endcase
    end else begin
      accept_next = 1'b1;
    end

    if (accept_next && req_valid_i) begin
      unique case (req_i.mode)
        mode_lookup: begin
          req_ready_o = 1'b1;
          busy_d      = 1'b1;
          mode_d      = mode_lookup;
          // flushed ways never take part in a lookup
          mask_d      = ~flushed_i;
          index_d     = req_i.index;
          tag_d       = new_entry;
          ram_req     = ~flushed_i;
        end
        mode_store: begin
          // no result, so the unit stays idle
          req_ready_o = 1'b1;
          ram_req     = req_i.way_mask;
          ram_we      = req_i.way_mask;
        end
        mode_flush: begin
          // slow modes wait for a fully idle unit
          if (!busy_q) begin
            req_ready_o = 1'b1;
            busy_d      = 1'b1;
            mode_d      = mode_flush;
            mask_d      = req_i.way_mask;
            index_d     = req_i.index;
            ram_req     = req_i.way_mask;
          end
        end
        mode_bist: begin
          if (!busy_q) begin
            gen_start = 1'b1;
            if (gen_ready) begin
              req_ready_o = 1'b1;
              busy_d      = 1'b1;
              mode_d      = mode_bist;
              mask_d      = req_i.way_mask;
            end
          end
        end
        default: begin
          req_ready_o = 1'b0;
        end
      endcase
    end
  end

  for (genvar i = 0; i < num_ways; i++) begin : gen_way
    tag_sram u_tag_sram (
      .clk_i   (clk_i),
      .req_i   (ram_req[i]),
      .we_i    (ram_we[i]),
      .addr_i  (ram_index),
      .wdata_i (ram_wdata),
      .rdata_o (rdata[i])
    );

    assign valid_mask[i] = rdata[i].valid;
    assign dirty_mask[i] = rdata[i].dirty;
    assign tag_match[i]  = (rdata[i].tag == tag_q.tag);
    assign hit[i]        = mask_q[i] & valid_mask[i] & tag_match[i];
    // bist compares the whole entry and ways outside the run always pass
    assign cmp[i]        = ~mask_q[i] | (rdata[i] == tag_q);
  end

  assign hit_any = |hit;

  always_comb begin : proc_result
    res_valid_o = 1'b0;
    res_way     = '0;
    res_o       = '0;
    evict_req   = 1'b0;
    if (busy_q) begin
      if (mode_q == mode_flush) begin
        res_valid_o = 1'b1;
        res_way     = mask_q;
        // write-back only for a valid dirty line
        res_o.evict = |(mask_q & valid_mask & dirty_mask);
      end else if (mode_q == mode_lookup) begin
        res_valid_o = 1'b1;
        if (hit_any) begin
          res_way   = hit;
          res_o.hit = 1'b1;
        end else begin
          evict_req   = 1'b1;
          res_way     = victim;
          res_o.evict = victim_evict;
        end
      end
    end
    res_o.way_mask = res_way;
    // old tag and dirty flag from the indicated way
    for (int i = 0; i < num_ways; i++) begin
      if (res_way[i]) begin
        res_o.tag   = rdata[i].tag;
        res_o.dirty = rdata[i].dirty;
      end
    end
  end

  // round-robin moves on once a miss is consumed
  assign evict_advance = evict_req & res_ready_i;

  tag_bist_gen u_tag_bist_gen (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (gen_start),
    .ready_o     (gen_ready),
    .index_o     (gen_index),
    .pattern_o   (gen_pattern),
    .req_o       (gen_req),
    .we_o        (gen_we),
    .cmp_i       (cmp),
    .cmp_valid_i (bist_rd_q),
    .bist_res_o  (bist_res_o),
    .done_o      (gen_done)
  );

  assign bist_valid_o = gen_done;

  evict_select u_evict_select (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (evict_req),
    .valid_i    (valid_mask),
    .dirty_i    (dirty_mask),
    .spm_lock_i (spm_lock_i),
    .advance_i  (evict_advance),
    .way_o      (victim),
    .evict_o    (victim_evict)
  );

  // control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      mode_q    <= mode_bist;
      bist_rd_q <= 1'b0;
    end else begin
      busy_q    <= busy_d;
      mode_q    <= mode_d;
      bist_rd_q <= bist_rd_d;
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    mask_q  <= mask_d;
    index_q <= index_d;
    tag_q   <= tag_d;
  end

  // a tag may live in only one way of a set
  hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    (busy_q && mode_q == mode_lookup) |-> $onehot0(hit))
    else $error("lookup hit in more than one way");

  // result and its fields must wait for the consumer
  res_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
    else $error("res_valid_o dropped or res_o changed before res_ready_i");

endmodule

//--- tag_bist_gen.sv
// bist sequencer for the tag memories, drives write/read/clear passes and collects the failure mask
`timescale 1ns/100ps
module tag_bist_gen
  import llc_tag_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       start_i,
  output logic       ready_o,
  output index_t     index_o,
  output tag_entry_t pattern_o,
  output logic       req_o,
  output logic       we_o,
  input  way_mask_t  cmp_i,
  input  logic       cmp_valid_i,
  output way_mask_t  bist_res_o,
  output logic       done_o
);

  // pass sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_write,
    st_read,
    st_clear,
    st_done
  } state_e;

  state_e     state_q, state_d;
  index_t     index_q, index_d;
  way_mask_t  fail_q, fail_d;
  logic       last_index;
  tag_entry_t alt_pattern;

  // all ones on odd sets, all zeros on even sets
  assign alt_pattern = tag_entry_t'({$bits(tag_entry_t){index_q[0]}});
  assign last_index  = (index_q == index_t'(num_lines - 1));

  assign ready_o    = (state_q == st_idle);
  assign index_o    = index_q;
  assign bist_res_o = fail_q;

  always_comb begin : proc_seq
    state_d   = state_q;
    index_d   = index_q;
    fail_d    = fail_q;
    req_o     = 1'b0;
    we_o      = 1'b0;
    done_o    = 1'b0;
    pattern_o = '0;
    unique case (state_q)
      st_idle: begin
        if (start_i) begin
          state_d = st_write;
          index_d = '0;
          // fresh failure mask for every run
          fail_d  = '0;
        end
      end
      st_write: begin
        req_o     = 1'b1;
        we_o      = 1'b1;
        pattern_o = alt_pattern;
        index_d   = index_q + 1'b1;
        if (last_index) begin
          state_d = st_read;
        end
      end
      st_read: begin
        // store compares against the pattern it registers here
        req_o     = 1'b1;
        pattern_o = alt_pattern;
        index_d   = index_q + 1'b1;
        if (last_index) begin
          state_d = st_clear;
        end
      end
      st_clear: begin
        // zeros leave every line invalid and clean
        req_o   = 1'b1;
        we_o    = 1'b1;
        index_d = index_q + 1'b1;
        if (last_index) begin
          state_d = st_done;
        end
      end
      st_done: begin
        done_o  = 1'b1;
        state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
    // last read compare lands in the first clear cycle
    if (cmp_valid_i) begin
      fail_d = fail_d | ~cmp_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
      index_q <= '0;
      fail_q  <= '0;
    end else begin
      state_q <= state_d;
      index_q <= index_d;
      fail_q  <= fail_d;
    end
  end

  // the store may only launch a run while the sequencer sits idle
  start_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> (state_q == st_idle))
    else $error("bist start while sequencer busy");

endmodule

//--- tag_sram.sv
// single-port tag memory for one way, one-cycle read latency, instantiated once per way
`timescale 1ns/100ps
module tag_sram
  import llc_tag_pkg::*;
(
  input  logic       clk_i,
  input  logic       req_i,
  input  logic       we_i,
  input  index_t     addr_i,
  input  tag_entry_t wdata_i,
  output tag_entry_t rdata_o
);

  // one entry per set
  tag_entry_t mem [num_lines];

  // write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // read port
  // data shows up on the edge after the request
  // and is held until the next read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- tag_store_cases.txt
# chain mode lock flushed way_mask index dirty tag | exp_way exp_hit exp_evict exp_tag exp_dirty
# hex; mode 0 bist 1 flush 2 lookup 3 store; bist puts its failure mask in exp_way; chain 1 = back-to-back
# bist over all ways, then a lookup on the cleared array takes way 0
0 0 0 0 f 0 0 00 0 0 0 00 0
0 2 0 0 0 3 0 5a 1 0 0 00 0
# dirty line in way 2, lookup hits it
0 3 0 0 4 5 1 a7 0 0 0 00 0
0 2 0 0 0 5 0 a7 4 1 0 a7 1
# fill set 7 in all ways
0 3 0 0 1 7 0 11 0 0 0 00 0
0 3 0 0 2 7 1 22 0 0 0 00 0
0 3 0 0 4 7 1 33 0 0 0 00 0
0 3 0 0 8 7 0 44 0 0 0 00 0
# misses on the full set walk the round-robin pointer, skipping locked ways
0 2 0 0 0 7 0 99 1 0 0 11 0
0 2 2 0 0 7 0 99 4 0 1 33 1
0 2 0 0 0 7 0 99 8 0 0 44 0
0 2 1 0 0 7 0 99 2 0 1 22 1
# flush dirty line twice, then it misses and its way is refilled first
0 1 0 0 4 7 0 00 4 0 1 33 1
0 1 0 0 4 7 0 00 4 0 0 00 0
0 2 0 0 0 7 0 33 4 0 0 00 0
# set 9 with lines in ways 1 and 3
0 3 0 0 2 9 0 c3 0 0 0 00 0
0 3 0 0 8 9 1 5e 0 0 0 00 0
# flushed way 1 cannot hit, then back-to-back lookups
0 2 0 2 0 9 0 c3 1 0 0 00 0
1 2 0 2 0 9 0 5e 8 1 0 5e 1
1 2 0 0 0 9 0 c3 2 1 0 c3 0
1 2 0 4 0 5 0 a7 1 0 0 00 0

//--- tb_llc_tag_store.sv
// testbench for the tag array top level, replays tag_store_cases.txt and checks every result
`timescale 1ns/100ps
module tb_llc_tag_store
  import llc_tag_pkg::*;
();

  // one line of the case file
  typedef struct packed {
    logic      chain;
    tag_req_t  req;
    way_mask_t lock;
    way_mask_t flushed;
    tag_res_t  exp;
    way_mask_t exp_bist;
  } case_t;

  logic      clk_i;
  logic      reset_i;
  way_mask_t spm_lock_i;
  way_mask_t flushed_i;
  logic      req_valid_i;
  logic      req_ready_o;
  tag_req_t  req_i;
  logic      res_valid_o;
  logic      res_ready_i;
  tag_res_t  res_o;
  way_mask_t bist_res_o;
  logic      bist_valid_o;

  case_t       cases[$];
  logic [31:0] rng;
  logic        aborted;
  // next request already driven together with res_ready_i
  logic        preloaded;
  int          case_errors;
  int          cases_passed;
  int          cases_failed;

  llc_tag_store UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .spm_lock_i   (spm_lock_i),
    .flushed_i    (flushed_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_o        (res_o),
    .bist_res_o   (bist_res_o),
    .bist_valid_o (bist_valid_o)
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // xorshift32 step for the back-pressure lengths
  function automatic logic [31:0] next_random(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic string mode_name(input tag_req_e m);
    case (m)
      mode_bist:   return "bist";
      mode_flush:  return "flush";
      mode_lookup: return "lookup";
      default:     return "store";
    endcase
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      case_errors++;
    end
  endtask

  // fill the case queue, hex columns as listed in the file header
  task automatic load_cases();
    int          fd;
    int          code;
    string       line;
    case_t       c;
    int unsigned f_chain, f_mode, f_lock, f_flushed, f_mask, f_index, f_dirty, f_tag;
    int unsigned e_way, e_hit, e_evict, e_tag, e_dirty;
    fd = $fopen("tag_store_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open tag_store_cases.txt");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0) begin
        break;
      end
      // blank lines and comments
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                     f_chain, f_mode, f_lock, f_flushed, f_mask, f_index, f_dirty, f_tag,
                     e_way, e_hit, e_evict, e_tag, e_dirty);
      if (code != 13) begin
        $display("malformed line in case file: %s", line);
        aborted = 1'b1;
        continue;
      end
      c                = '0;
      c.chain          = f_chain[0];
      c.req.mode       = tag_req_e'(f_mode[1:0]);
      c.req.way_mask   = way_mask_t'(f_mask);
      c.req.index      = index_t'(f_index);
      c.req.dirty      = f_dirty[0];
      c.req.tag        = tag_t'(f_tag);
      c.lock           = way_mask_t'(f_lock);
      c.flushed        = way_mask_t'(f_flushed);
      // bist lines reuse the way column for the failure mask
      if (c.req.mode == mode_bist) begin
        c.exp_bist = way_mask_t'(e_way);
      end else begin
        c.exp.way_mask = way_mask_t'(e_way);
        c.exp.hit      = e_hit[0];
        c.exp.evict    = e_evict[0];
        c.exp.tag      = tag_t'(e_tag);
        c.exp.dirty    = e_dirty[0];
      end
      cases.push_back(c);
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      $display("case file holds no cases");
      aborted = 1'b1;
    end
  endtask

  // called right after a rising edge
  task automatic apply_request(input case_t c);
    req_valid_i <= 1'b1;
    req_i       <= c.req;
    spm_lock_i  <= c.lock;
    flushed_i   <= c.flushed;
  endtask

  // called at a falling edge, returns at the falling edge where req_ready_o is high
  task automatic wait_req_ready();
    int n;
    n = 0;
    while (!req_ready_o) begin
      if (n >= 100) begin
        $display("timeout, request was never accepted");
        aborted = 1'b1;
        return;
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic wait_bist_done();
    int n;
    n = 0;
    while (!bist_valid_o) begin
      if (n >= 200) begin
        $display("timeout, bist run never signalled done");
        aborted = 1'b1;
        return;
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic run_case(input int idx);
    case_t    c;
    tag_res_t held;
    int       stall;
    c           = cases[idx];
    case_errors = 0;
    if (!preloaded) begin
      @(posedge clk_i);
      apply_request(c);
      @(negedge clk_i);
    end
    preloaded = 1'b0;
    wait_req_ready();
    if (aborted) begin
      return;
    end
    // handshake edge
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    res_ready_i <= 1'b0;
    if (c.req.mode == mode_bist) begin
      @(negedge clk_i);
      wait_bist_done();
      if (aborted) begin
        return;
      end
      check_field("bist_res_o", bist_res_o, c.exp_bist);
      // done is a single cycle pulse
      @(negedge clk_i);
      check_field("bist_valid_o", bist_valid_o, 1'b0);
    end else if (c.req.mode != mode_store) begin
      // result due one cycle after acceptance
      @(negedge clk_i);
      check_field("res_valid_o", res_valid_o, 1'b1);
      held  = res_o;
      rng   = next_random(rng);
      stall = rng % 4;
      // back-pressure, result must stay put
      repeat (stall) begin
        @(posedge clk_i);
        @(negedge clk_i);
        check_field("res_valid_o", res_valid_o, 1'b1);
        check_field("res_o", res_o, held);
      end
      @(posedge clk_i);
      res_ready_i <= 1'b1;
      // chained lookup goes out in the cycle this result is taken
      if (idx + 1 < cases.size() && cases[idx + 1].chain) begin
        apply_request(cases[idx + 1]);
        preloaded = 1'b1;
      end
      @(negedge clk_i);
      check_field("res_valid_o", res_valid_o, 1'b1);
      check_field("res_o.way_mask", res_o.way_mask, c.exp.way_mask);
      check_field("res_o.hit", res_o.hit, c.exp.hit);
      check_field("res_o.evict", res_o.evict, c.exp.evict);
      check_field("res_o.tag", res_o.tag, c.exp.tag);
      check_field("res_o.dirty", res_o.dirty, c.exp.dirty);
      if (preloaded) begin
        check_field("req_ready_o", req_ready_o, 1'b1);
      end else begin
        @(posedge clk_i);
        res_ready_i <= 1'b0;
      end
    end
    if (case_errors == 0) begin
      cases_passed++;
      $display("case %0d %s ok", idx, mode_name(c.req.mode));
    end else begin
      cases_failed++;
      $display("case %0d %s FAILED with %0d errors", idx, mode_name(c.req.mode), case_errors);
    end
  endtask

  initial begin : main
    // every input starts defined, reset held
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_i        = '0;
    res_ready_i  = 1'b0;
    spm_lock_i   = '0;
    flushed_i    = '0;
    rng          = 32'hfab5;
    aborted      = 1'b0;
    preloaded    = 1'b0;
    case_errors  = 0;
    cases_passed = 0;
    cases_failed = 0;
    load_cases();
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int i = 0; i < cases.size() && !aborted; i++) begin
      run_case(i);
    end
    $display("cases run %0d, passed %0d, failed %0d",
             cases_passed + cases_failed, cases_passed, cases_failed);
    if (!aborted && cases_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
